// ==== nds_exec_pkg.sv ====
package nds_exec_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [4:0]  shamt_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [4:0]  sub_opcode_t;

  // Major opcodes, instruction bits 30 to 25.
  localparam opcode_t OP_ALU1 = 6'b100000;
  localparam opcode_t OP_ADDI = 6'b101000;
  localparam opcode_t OP_ORI  = 6'b101100;
  localparam opcode_t OP_XORI = 6'b101011;
  localparam opcode_t OP_MOVI = 6'b100010;

  // ALU_1 sub-opcodes, instruction bits 4 to 0.
  localparam sub_opcode_t SUB_ADD   = 5'b00000;
  localparam sub_opcode_t SUB_SUB   = 5'b00001;
  localparam sub_opcode_t SUB_AND   = 5'b00010;
  localparam sub_opcode_t SUB_XOR   = 5'b00011;
  localparam sub_opcode_t SUB_OR    = 5'b00100;
  localparam sub_opcode_t SUB_SLLI  = 5'b01000;
  localparam sub_opcode_t SUB_SRLI  = 5'b01001;
  localparam sub_opcode_t SUB_ROTRI = 5'b01011;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SRL,
    ALU_SLL,
    ALU_ROTR,
    ALU_PASS
  } alu_op_e;

endpackage

// ==== instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
  input  nds_exec_pkg::instr_t   instr,
  output nds_exec_pkg::reg_idx_t ra_idx,
  output nds_exec_pkg::reg_idx_t rb_idx,
  output nds_exec_pkg::reg_idx_t rt_idx,
  output nds_exec_pkg::alu_op_e  alu_op,
  output logic                   use_imm,
  output nds_exec_pkg::word_t    imm,
  output nds_exec_pkg::shamt_t   shamt,
  output logic                   legal
);
  import nds_exec_pkg::*;

  opcode_t     opcode;
  sub_opcode_t sub_op;
  word_t       imm15_sext;
  word_t       imm15_zext;
  word_t       imm20_sext;

  // Bit 31 is not part of any field.
  assign opcode = instr[30:25];
  assign sub_op = instr[4:0];
  assign rt_idx = instr[24:20];
  assign ra_idx = instr[19:15];
  assign rb_idx = instr[14:10];

  // The rb field doubles as the immediate shift amount.
  assign shamt = instr[14:10];

  assign imm15_sext = {{17{instr[14]}}, instr[14:0]};
  assign imm15_zext = {17'b0, instr[14:0]};
  assign imm20_sext = {{12{instr[19]}}, instr[19:0]};

  always_comb begin
    alu_op  = ALU_PASS;
    use_imm = 1'b0;
    imm     = '0;
    legal   = 1'b1;
    case (opcode)
      OP_ALU1: begin
        case (sub_op)
          SUB_ADD:   alu_op = ALU_ADD;
          SUB_SUB:   alu_op = ALU_SUB;
          SUB_AND:   alu_op = ALU_AND;
          SUB_OR:    alu_op = ALU_OR;
          SUB_XOR:   alu_op = ALU_XOR;
          SUB_SRLI:  alu_op = ALU_SRL;
          SUB_SLLI:  alu_op = ALU_SLL;
          SUB_ROTRI: alu_op = ALU_ROTR;
          default:   legal = 1'b0;
        endcase
      end
      OP_ADDI: begin
        alu_op  = ALU_ADD;
        use_imm = 1'b1;
        imm     = imm15_sext;
      end
      OP_ORI: begin
        alu_op  = ALU_OR;
        use_imm = 1'b1;
        imm     = imm15_zext;
      end
      OP_XORI: begin
        alu_op  = ALU_XOR;
        use_imm = 1'b1;
        imm     = imm15_zext;
      end
      // MOVI passes the immediate straight through the ALU.
      OP_MOVI: begin
        alu_op  = ALU_PASS;
        use_imm = 1'b1;
        imm     = imm20_sext;
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic                   clk,
  input  logic                   reset,
  input  nds_exec_pkg::reg_idx_t ra_idx,
  input  nds_exec_pkg::reg_idx_t rb_idx,
  output nds_exec_pkg::word_t    ra_data,
  output nds_exec_pkg::word_t    rb_data,
  input  logic                   wr_en,
  input  nds_exec_pkg::reg_idx_t wr_idx,
  input  nds_exec_pkg::word_t    wr_data
);
  import nds_exec_pkg::*;

  localparam int NUM_REGS = 32;

  word_t regs [NUM_REGS];

  // R0 is not hardwired to zero and is written like any other register.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Asynchronous reads.
  assign ra_data = regs[ra_idx];
  assign rb_data = regs[rb_idx];

endmodule

// ==== alu32.sv ====
`timescale 1ns/1ps

module alu32 (
  input  nds_exec_pkg::word_t   op_a,
  input  nds_exec_pkg::word_t   op_b,
  input  nds_exec_pkg::shamt_t  shamt,
  input  nds_exec_pkg::alu_op_e alu_op,
  output nds_exec_pkg::word_t   alu_result,
  output logic                  alu_overflow
);
  import nds_exec_pkg::*;

  word_t sum;
  word_t diff;
  word_t rot_word;
  logic  add_ovf;
  logic  sub_ovf;

  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  // Rotate right by shifting a doubled copy of the operand.
  assign rot_word = word_t'({op_a, op_a} >> shamt);

  // Same input signs, different result sign.
  assign add_ovf = (op_a[31] == op_b[31]) && (sum[31] != op_a[31]);

  // Input signs differ and the result sign leaves op_a.
  assign sub_ovf = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);

  always_comb begin
    alu_result   = '0;
    alu_overflow = 1'b0;
    case (alu_op)
      ALU_ADD: begin
        alu_result   = sum;
        alu_overflow = add_ovf;
      end
      ALU_SUB: begin
        alu_result   = diff;
        alu_overflow = sub_ovf;
      end
      ALU_AND: begin
        alu_result = op_a & op_b;
      end
      ALU_OR: begin
        alu_result = op_a | op_b;
      end
      ALU_XOR: begin
        alu_result = op_a ^ op_b;
      end
      // Shift by zero leaves the operand as it is.
      ALU_SRL: begin
        alu_result = op_a >> shamt;
      end
      ALU_SLL: begin
        alu_result = op_a << shamt;
      end
      ALU_ROTR: begin
        alu_result = rot_word;
      end
      ALU_PASS: begin
        alu_result = op_b;
      end
      default: begin
        alu_result = '0;
      end
    endcase
  end

endmodule

// ==== writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   instr_valid,
  input  logic                   legal,
  input  nds_exec_pkg::reg_idx_t rt_idx,
  input  nds_exec_pkg::word_t    alu_result,
  input  logic                   alu_overflow,
  output logic                   wr_en,
  output nds_exec_pkg::reg_idx_t wr_idx,
  output nds_exec_pkg::word_t    wr_data,
  output logic                   result_valid,
  output logic                   illegal,
  output nds_exec_pkg::word_t    result_data,
  output logic                   result_overflow,
  output nds_exec_pkg::reg_idx_t result_reg
);
  import nds_exec_pkg::*;

  logic refuse;

  // Register write lands on the same edge that raises result_valid.
  assign wr_en   = instr_valid & legal;
  assign wr_idx  = rt_idx;
  assign wr_data = alu_result;

  assign refuse = instr_valid & ~legal;

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      illegal      <= 1'b0;
    end else begin
      result_valid <= wr_en;
      illegal      <= refuse;
    end
  end

  // Result fields hold the last completed instruction.
  always_ff @(posedge clk) begin
    if (reset) begin
      result_data     <= '0;
      result_overflow <= 1'b0;
      result_reg      <= '0;
    end else if (wr_en) begin
      result_data     <= alu_result;
      result_overflow <= alu_overflow;
      result_reg      <= rt_idx;
    end
  end

endmodule

// ==== execute_core.sv ====
`timescale 1ns/1ps

module execute_core (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   instr_valid,
  input  nds_exec_pkg::instr_t   instr,
  output logic                   result_valid,
  output logic                   illegal,
  output nds_exec_pkg::word_t    result_data,
  output logic                   result_overflow,
  output nds_exec_pkg::reg_idx_t result_reg
);
  import nds_exec_pkg::*;

  reg_idx_t ra_idx;
  reg_idx_t rb_idx;
  reg_idx_t rt_idx;
  alu_op_e  alu_op;
  logic     use_imm;
  word_t    imm;
  shamt_t   shamt;
  logic     dec_legal;
  word_t    ra_data;
  word_t    rb_data;
  word_t    op_b;
  word_t    alu_result;
  logic     alu_overflow;
  logic     rf_wr_en;
  reg_idx_t rf_wr_idx;
  word_t    rf_wr_data;

  instr_decoder i_decoder (
    .instr   (instr),
    .ra_idx  (ra_idx),
    .rb_idx  (rb_idx),
    .rt_idx  (rt_idx),
    .alu_op  (alu_op),
    .use_imm (use_imm),
    .imm     (imm),
    .shamt   (shamt),
    .legal   (dec_legal)
  );

  register_file i_regfile (
    .clk     (clk),
    .reset   (reset),
    .ra_idx  (ra_idx),
    .rb_idx  (rb_idx),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .wr_en   (rf_wr_en),
    .wr_idx  (rf_wr_idx),
    .wr_data (rf_wr_data)
  );

  // Operand b comes from the immediate for the I-type forms.
  assign op_b = use_imm ? imm : rb_data;

  alu32 i_alu (
    .op_a         (ra_data),
    .op_b         (op_b),
    .shamt        (shamt),
    .alu_op       (alu_op),
    .alu_result   (alu_result),
    .alu_overflow (alu_overflow)
  );

  writeback_stage i_writeback (
    .clk             (clk),
    .reset           (reset),
    .instr_valid     (instr_valid),
    .legal           (dec_legal),
    .rt_idx          (rt_idx),
    .alu_result      (alu_result),
    .alu_overflow    (alu_overflow),
    .wr_en           (rf_wr_en),
    .wr_idx          (rf_wr_idx),
    .wr_data         (rf_wr_data),
    .result_valid    (result_valid),
    .illegal         (illegal),
    .result_data     (result_data),
    .result_overflow (result_overflow),
    .result_reg      (result_reg)
  );

endmodule

// ==== execute_core_chk.sv ====
`timescale 1ns/1ps

module execute_core_chk (
  input logic                   clk,
  input logic                   reset,
  input logic                   instr_valid,
  input logic                   result_valid,
  input logic                   illegal,
  input nds_exec_pkg::word_t    result_data,
  input logic                   result_overflow,
  input nds_exec_pkg::reg_idx_t result_reg
);
  int unsigned fail_count = 0;

  // Every accepted instruction completes exactly one cycle later.
  a_completion: assert property (@(posedge clk) disable iff (reset)
    instr_valid |=> (result_valid || illegal))
    else begin
      fail_count++;
      $error("No completion strobe one cycle after instr_valid");
    end

  a_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(result_valid && illegal))
    else begin
      fail_count++;
      $error("result_valid and illegal are high together");
    end

  // A strobe always has an instruction behind it.
  a_no_spurious: assert property (@(posedge clk) disable iff (reset)
    (result_valid || illegal) |-> $past(instr_valid))
    else begin
      fail_count++;
      $error("Completion strobe without a preceding instr_valid");
    end

  a_reset_outputs: assert property (@(posedge clk)
    reset |=> (!result_valid && !illegal && result_data == '0 &&
               !result_overflow && result_reg == '0))
    else begin
      fail_count++;
      $error("Outputs are not cleared by reset");
    end

endmodule

bind execute_core execute_core_chk i_chk (
  .clk             (clk),
  .reset           (reset),
  .instr_valid     (instr_valid),
  .result_valid    (result_valid),
  .illegal         (illegal),
  .result_data     (result_data),
  .result_overflow (result_overflow),
  .result_reg      (result_reg)
);

// ==== tb_execute_core.sv ====
`timescale 1ns/1ps

module tb_execute_core;
  import nds_exec_pkg::*;

  logic     clk;
  logic     reset;
  logic     instr_valid;
  instr_t   instr;
  logic     result_valid;
  logic     illegal;
  word_t    result_data;
  logic     result_overflow;
  reg_idx_t result_reg;

  word_t       model_regs [32];
  logic [31:0] rng_state = 32'd77011;
  string       test_name;

  execute_core i_dut (
    .clk             (clk),
    .reset           (reset),
    .instr_valid     (instr_valid),
    .instr           (instr),
    .result_valid    (result_valid),
    .illegal         (illegal),
    .result_data     (result_data),
    .result_overflow (result_overflow),
    .result_reg      (result_reg)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] draw_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic instr_t enc_alu1(input sub_opcode_t sub, input reg_idx_t rt,
                                      input reg_idx_t ra, input reg_idx_t rb);
    return {1'b0, OP_ALU1, rt, ra, rb, 5'd0, sub};
  endfunction

  function automatic instr_t enc_imm15(input opcode_t op, input reg_idx_t rt,
                                       input reg_idx_t ra, input logic [14:0] imm);
    return {1'b0, op, rt, ra, imm};
  endfunction

  function automatic instr_t enc_movi(input reg_idx_t rt, input logic [19:0] imm);
    return {1'b0, OP_MOVI, rt, imm};
  endfunction

  function automatic logic out_of_range(input longint v);
    return (v > 64'sd2147483647) || (v < -64'sd2147483648);
  endfunction

  // Reference model of one instruction against the model register file.
  function automatic void predict(input instr_t ins, output word_t res, output logic ovf,
                                  output logic ok);
    opcode_t     op;
    sub_opcode_t sub;
    word_t       a;
    word_t       b;
    word_t       imm_s;
    shamt_t      n;
    op    = ins[30:25];
    sub   = ins[4:0];
    a     = model_regs[ins[19:15]];
    b     = model_regs[ins[14:10]];
    n     = ins[14:10];
    imm_s = int'($signed(ins[14:0]));
    res   = '0;
    ovf   = 1'b0;
    ok    = 1'b1;
    if (op == OP_ALU1) begin
      case (sub)
        SUB_ADD: begin
          res = a + b;
          ovf = out_of_range(longint'($signed(a)) + longint'($signed(b)));
        end
        SUB_SUB: begin
          res = a - b;
          ovf = out_of_range(longint'($signed(a)) - longint'($signed(b)));
        end
        SUB_AND:   res = a & b;
        SUB_OR:    res = a | b;
        SUB_XOR:   res = a ^ b;
        SUB_SRLI:  res = (n == 0) ? a : (a >> n);
        SUB_SLLI:  res = (n == 0) ? a : (a << n);
        SUB_ROTRI: res = (n == 0) ? a : ((a >> n) | (a << (32 - n)));
        default:   ok = 1'b0;
      endcase
    end else if (op == OP_ADDI) begin
      res = a + imm_s;
      ovf = out_of_range(longint'($signed(a)) + longint'($signed(imm_s)));
    end else if (op == OP_ORI) begin
      res = a | {17'd0, ins[14:0]};
    end else if (op == OP_XORI) begin
      res = a ^ {17'd0, ins[14:0]};
    end else if (op == OP_MOVI) begin
      res = int'($signed(ins[19:0]));
    end else begin
      ok = 1'b0;
    end
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp)
      else abort_run($sformatf("FAILED %s %s: expected %h, actual %h",
                               test_name, field, exp, act));
  endtask

  // Drives one instruction for one cycle, then checks its completion.
  task automatic run_instr(input instr_t ins);
    word_t exp_res;
    logic  exp_ovf;
    logic  exp_ok;
    int    waited;
    predict(ins, exp_res, exp_ovf, exp_ok);
    instr_valid = 1'b1;
    instr       = ins;
    @(posedge clk);
    #2;
    instr_valid = 1'b0;
    instr       = '0;
    waited      = 0;
    while (!(result_valid || illegal)) begin
      if (waited == 5) begin
        abort_run($sformatf("Timeout in test %s: no completion strobe", test_name));
      end
      @(posedge clk);
      #2;
      waited++;
    end
    if (exp_ok) begin
      check_value("result_valid", 32'd1, 32'(result_valid));
      check_value("illegal", 32'd0, 32'(illegal));
      check_value("result_data", exp_res, result_data);
      check_value("result_overflow", 32'(exp_ovf), 32'(result_overflow));
      check_value("result_reg", 32'(ins[24:20]), 32'(result_reg));
      model_regs[ins[24:20]] = exp_res;
    end else begin
      check_value("illegal", 32'd1, 32'(illegal));
      check_value("result_valid", 32'd0, 32'(result_valid));
    end
  endtask

  task automatic test_reset_state();
    int i;
    test_name = "reset_state";
    for (i = 0; i < 32; i++) begin
      run_instr(enc_alu1(SUB_ADD, reg_idx_t'(i), reg_idx_t'(i), reg_idx_t'(i)));
    end
  endtask

  task automatic test_movi();
    int          i;
    logic [31:0] r;
    logic [19:0] imm20;
    test_name = "movi";
    for (i = 0; i < 32; i++) begin
      r         = draw_random();
      imm20     = r[19:0];
      imm20[19] = i[0];
      run_instr(enc_movi(reg_idx_t'(i), imm20));
    end
  endtask

  task automatic test_arith();
    int          i;
    logic [31:0] r;
    test_name = "arith_limits";
    run_instr(enc_movi(5'd1, 20'hFFFFF));
    run_instr(enc_alu1(SUB_SRLI, 5'd1, 5'd1, 5'd1));
    run_instr(enc_movi(5'd2, 20'd1));
    run_instr(enc_alu1(SUB_ADD, 5'd3, 5'd1, 5'd2));
    run_instr(enc_alu1(SUB_SLLI, 5'd4, 5'd2, 5'd31));
    run_instr(enc_alu1(SUB_SUB, 5'd5, 5'd4, 5'd2));
    run_instr(enc_alu1(SUB_SUB, 5'd6, 5'd1, 5'd4));
    run_instr(enc_alu1(SUB_ADD, 5'd7, 5'd4, 5'd4));
    run_instr(enc_imm15(OP_ADDI, 5'd8, 5'd1, 15'd1));
    run_instr(enc_imm15(OP_ADDI, 5'd9, 5'd4, 15'h7FFF));
    test_name = "arith_random";
    for (i = 0; i < 60; i++) begin
      r = draw_random();
      case (r[1:0])
        2'd0:    run_instr(enc_alu1(SUB_ADD, r[6:2], r[11:7], r[16:12]));
        2'd1:    run_instr(enc_alu1(SUB_SUB, r[6:2], r[11:7], r[16:12]));
        2'd2:    run_instr(enc_imm15(OP_ADDI, r[6:2], r[11:7], r[31:17]));
        default: run_instr(enc_alu1(SUB_SLLI, r[6:2], r[11:7], r[16:12]));
      endcase
    end
  endtask

  task automatic test_logic();
    int          i;
    logic [31:0] r;
    test_name = "logic";
    for (i = 0; i < 40; i++) begin
      r = draw_random();
      case (r[2:0])
        3'd0, 3'd7: run_instr(enc_alu1(SUB_AND, r[7:3], r[12:8], r[17:13]));
        3'd1:       run_instr(enc_alu1(SUB_OR, r[7:3], r[12:8], r[17:13]));
        3'd2:       run_instr(enc_alu1(SUB_XOR, r[7:3], r[12:8], r[17:13]));
        3'd3, 3'd4: run_instr(enc_imm15(OP_ORI, r[7:3], r[12:8], r[31:17]));
        default:    run_instr(enc_imm15(OP_XORI, r[7:3], r[12:8], r[31:17]));
      endcase
    end
  endtask

  task automatic test_shifts();
    int          amt;
    logic [31:0] r;
    reg_idx_t    src;
    reg_idx_t    dst;
    test_name = "shifts";
    for (amt = 0; amt < 32; amt++) begin
      r   = draw_random();
      src = r[4:0];
      dst = src ^ 5'd1;
      // Build a full 32-bit operand from three instructions.
      run_instr(enc_movi(src, r[24:5]));
      run_instr(enc_alu1(SUB_SLLI, src, src, 5'd12));
      r = draw_random();
      run_instr(enc_imm15(OP_XORI, src, src, r[14:0]));
      run_instr(enc_alu1(SUB_SRLI, dst, src, shamt_t'(amt)));
      run_instr(enc_alu1(SUB_SLLI, dst, src, shamt_t'(amt)));
      run_instr(enc_alu1(SUB_ROTRI, dst, src, shamt_t'(amt)));
    end
  endtask

  // Each instruction goes in the cycle right after its producer.
  task automatic test_back_to_back();
    test_name = "back_to_back";
    run_instr(enc_movi(5'd20, 20'h12345));
    run_instr(enc_alu1(SUB_ADD, 5'd21, 5'd20, 5'd20));
    run_instr(enc_imm15(OP_ADDI, 5'd21, 5'd21, 15'd7));
    run_instr(enc_alu1(SUB_XOR, 5'd22, 5'd21, 5'd20));
    run_instr(enc_alu1(SUB_ROTRI, 5'd22, 5'd22, 5'd4));
    run_instr(enc_alu1(SUB_SUB, 5'd22, 5'd22, 5'd21));
  endtask

  task automatic test_illegal();
    int          i;
    logic [31:0] r;
    test_name = "illegal";
    run_instr(enc_movi(5'd0, 20'd0));
    r = draw_random();
    run_instr({1'b0, 6'b111111, r[24:0]});
    run_instr({1'b1, 6'b000000, r[24:0]});
    run_instr({r[31], OP_ALU1, r[24:5], 5'b11111});
    run_instr({r[31], OP_ALU1, r[24:5], 5'b00101});
    test_name = "illegal_readback";
    for (i = 0; i < 32; i++) begin
      run_instr(enc_alu1(SUB_ADD, reg_idx_t'(i), reg_idx_t'(i), 5'd0));
    end
  endtask

  initial begin
    int i;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    test_name   = "reset";
    for (i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    test_reset_state();
    test_movi();
    test_arith();
    test_logic();
    test_shifts();
    test_back_to_back();
    test_illegal();
    // Let the bound assertions see the last strobe.
    repeat (2) @(posedge clk);
    #2;
    if (i_dut.i_chk.fail_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      abort_run("Bound assertion checks reported failures");
    end
  end

endmodule

// ==== list.f ====
nds_exec_pkg.sv
instr_decoder.sv
register_file.sv
alu32.sv
writeback_stage.sv
execute_core.sv
execute_core_chk.sv
tb_execute_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_execute_core
LOG       ?= sim.log
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# The run status is taken from the log, so a failing run still reaches the search.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
